//--- design/wb_commit_pkg.sv
// ----------------------------------------------------------------------
// Writeback and commit shared types
// Widths of the architectural fields carried from the execute pipes
// through completion and commit, plus the arbiter state encoding
// ----------------------------------------------------------------------

package wb_commit_pkg;

  // ----------------------------------------------------------------------
  // Field widths
  // ----------------------------------------------------------------------

  // Instruction address width
  localparam int pc_bits = 32;

  // Architectural register file has 32 entries
  localparam int reg_addr_bits = 5;

  // Integer datapath width
  localparam int word_bits = 32;

  // ----------------------------------------------------------------------
  // Typedefs
  // ----------------------------------------------------------------------

  // Program counter of a finished instruction
  typedef logic [pc_bits-1:0] pc_t;

  // Destination register address
  typedef logic [reg_addr_bits-1:0] reg_addr_t;

  // Register write data
  typedef logic [word_bits-1:0] word_t;

  // Arbiter grant pointer mode
  // idle means no grant since reset, so the search starts at pipe 0
  // granting means the search resumes after the last granted pipe
  typedef enum logic {
    idle,
    granting
  } arb_state_t;

endpackage

//--- design/writeback_arbiter.sv
// ----------------------------------------------------------------------
// Writeback arbiter
// Round-robin choice of one execute pipe per cycle, with the winner's
// fields registered into the completion notification
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module writeback_arbiter import wb_commit_pkg::*; #(
  parameter int p_num_pipes    = 2,
  parameter int p_seq_num_bits = 3
) (
  input  logic                                       clk,
  input  logic                                       rst_n,

  // Execute pipe side, one element per pipe
  input  logic [p_num_pipes-1:0]                     ex_val,
  output logic [p_num_pipes-1:0]                     ex_rdy,
  input  pc_t  [p_num_pipes-1:0]                     ex_pc,
  input  logic [p_num_pipes-1:0][p_seq_num_bits-1:0] ex_seq_num,
  input  reg_addr_t [p_num_pipes-1:0]                ex_waddr,
  input  word_t [p_num_pipes-1:0]                    ex_wdata,
  input  logic [p_num_pipes-1:0]                     ex_wen,

  // Completion notification
  output logic                                       complete_val,
  output pc_t                                        complete_pc,
  output logic [p_seq_num_bits-1:0]                  complete_seq_num,
  output reg_addr_t                                  complete_waddr,
  output word_t                                      complete_wdata,
  output logic                                       complete_wen
);

  // Index width, kept at 1 bit for a single pipe
  localparam int p_idx_bits = (p_num_pipes > 1) ? $clog2(p_num_pipes) : 1;

  arb_state_t            state;
  logic [p_idx_bits-1:0] last_grant;

  logic [p_idx_bits-1:0] grant_idx;
  logic                  grant_any;

  // ----------------------------------------------------------------------
  // Priority search
  // ----------------------------------------------------------------------

  // Walk the pipes starting one past the last grant, first val wins
  always_comb begin
    int start_idx;
    int cand;
    start_idx = 0;
    cand      = 0;
    grant_idx = '0;
    grant_any = 1'b0;
    if (state == granting) begin
      start_idx = int'(last_grant) + 1;
      if (start_idx >= p_num_pipes) begin
        start_idx = 0;
      end
    end
    for (int i = 0; i < p_num_pipes; i++) begin
      cand = start_idx + i;
      // Wrap around without a modulo for non power of two counts
      if (cand >= p_num_pipes) begin
        cand = cand - p_num_pipes;
      end
      if (!grant_any && ex_val[cand]) begin
        grant_any = 1'b1;
        grant_idx = p_idx_bits'(cand);
      end
    end
  end

  // One-hot ready, only the winner sees rdy
  always_comb begin
    ex_rdy = '0;
    if (grant_any) begin
      ex_rdy[grant_idx] = 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Grant pointer
  // ----------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= idle;
      last_grant <= '0;
    end else if (grant_any) begin
      state      <= granting;
      last_grant <= grant_idx;
    end
  end

  // ----------------------------------------------------------------------
  // Completion notification
  // ----------------------------------------------------------------------

  // Pulses the cycle after each transfer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      complete_val <= 1'b0;
    end else begin
      complete_val <= grant_any;
    end
  end

  // Payload capture of the granted pipe
  always_ff @(posedge clk) begin
    if (grant_any) begin
      complete_pc      <= ex_pc[grant_idx];
      complete_seq_num <= ex_seq_num[grant_idx];
      complete_waddr   <= ex_waddr[grant_idx];
      complete_wdata   <= ex_wdata[grant_idx];
      complete_wen     <= ex_wen[grant_idx];
    end
  end

endmodule

//--- design/reorder_buffer.sv
// ----------------------------------------------------------------------
// Reorder buffer
// Holds completed results by sequence number and retires them strictly
// in program order, one per cycle, as a commit notification
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module reorder_buffer import wb_commit_pkg::*; #(
  parameter int p_seq_num_bits = 3
) (
  input  logic                      clk,
  input  logic                      rst_n,

  // Completion notification from the arbiter
  input  logic                      complete_val,
  input  pc_t                       complete_pc,
  input  logic [p_seq_num_bits-1:0] complete_seq_num,
  input  reg_addr_t                 complete_waddr,
  input  word_t                     complete_wdata,
  input  logic                      complete_wen,

  // Commit notification
  output logic                      commit_val,
  output pc_t                       commit_pc,
  output logic [p_seq_num_bits-1:0] commit_seq_num,
  output reg_addr_t                 commit_waddr,
  output word_t                     commit_wdata,
  output logic                      commit_wen
);

  // One slot per sequence number
  localparam int p_depth = 2 ** p_seq_num_bits;

  // ----------------------------------------------------------------------
  // Storage
  // ----------------------------------------------------------------------

  // Slot occupancy
  logic [p_depth-1:0]        slot_val;

  // Slot payload
  pc_t                       slot_pc    [p_depth];
  reg_addr_t                 slot_waddr [p_depth];
  word_t                     slot_wdata [p_depth];
  logic                      slot_wen   [p_depth];

  // Oldest uncommitted sequence number
  logic [p_seq_num_bits-1:0] head;

  // Head entry as seen this cycle
  logic                      head_hit_stored;
  logic                      head_hit_bypass;
  logic                      head_ready;
  pc_t                       head_pc;
  reg_addr_t                 head_waddr;
  word_t                     head_wdata;
  logic                      head_wen;

  // ----------------------------------------------------------------------
  // Head lookup
  // ----------------------------------------------------------------------

  // Head already sitting in its slot
  assign head_hit_stored = slot_val[head];

  // Head arriving right now on the completion path
  assign head_hit_bypass = complete_val && (complete_seq_num == head);

  // Either source lets the head retire at the next edge
  assign head_ready = head_hit_stored || head_hit_bypass;

  // Stored entry wins, bypass only when the slot is still empty
  always_comb begin
    if (head_hit_stored) begin
      head_pc    = slot_pc[head];
      head_waddr = slot_waddr[head];
      head_wdata = slot_wdata[head];
      head_wen   = slot_wen[head];
    end else begin
      head_pc    = complete_pc;
      head_waddr = complete_waddr;
      head_wdata = complete_wdata;
      head_wen   = complete_wen;
    end
  end

  // ----------------------------------------------------------------------
  // Slot valid bits and head pointer
  // ----------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_val <= '0;
      head     <= '0;
    end else begin
      // Mark the completed slot
      if (complete_val) begin
        slot_val[complete_seq_num] <= 1'b1;
      end
      // Retire the head, this clear overrides a same-cycle bypass write
      if (head_ready) begin
        slot_val[head] <= 1'b0;
        // Wraps naturally, depth is a power of two
        head           <= head + 1'b1;
      end
    end
  end

  // Payload write at the completion index
  always_ff @(posedge clk) begin
    if (complete_val) begin
      slot_pc[complete_seq_num]    <= complete_pc;
      slot_waddr[complete_seq_num] <= complete_waddr;
      slot_wdata[complete_seq_num] <= complete_wdata;
      slot_wen[complete_seq_num]   <= complete_wen;
    end
  end

  // ----------------------------------------------------------------------
  // Commit notification
  // ----------------------------------------------------------------------

  // One pulse per retired entry
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      commit_val <= 1'b0;
    end else begin
      commit_val <= head_ready;
    end
  end

  // Commit fields, held between pulses
  always_ff @(posedge clk) begin
    if (head_ready) begin
      commit_pc      <= head_pc;
      commit_seq_num <= head;
      commit_waddr   <= head_waddr;
      commit_wdata   <= head_wdata;
      commit_wen     <= head_wen;
    end
  end

endmodule

//--- design/writeback_commit_unit.sv
// ----------------------------------------------------------------------
// Writeback and commit unit
// Arbiter over the execute pipes feeding an in-order reorder buffer
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module writeback_commit_unit import wb_commit_pkg::*; #(
  parameter int p_num_pipes    = 2,
  parameter int p_seq_num_bits = 3
) (
  input  logic                                       clk,
  input  logic                                       rst_n,

  // Execute pipes
  input  logic [p_num_pipes-1:0]                     ex_val,
  output logic [p_num_pipes-1:0]                     ex_rdy,
  input  pc_t  [p_num_pipes-1:0]                     ex_pc,
  input  logic [p_num_pipes-1:0][p_seq_num_bits-1:0] ex_seq_num,
  input  reg_addr_t [p_num_pipes-1:0]                ex_waddr,
  input  word_t [p_num_pipes-1:0]                    ex_wdata,
  input  logic [p_num_pipes-1:0]                     ex_wen,

  // Completion notification
  output logic                                       complete_val,
  output logic [p_seq_num_bits-1:0]                  complete_seq_num,
  output reg_addr_t                                  complete_waddr,
  output word_t                                      complete_wdata,
  output logic                                       complete_wen,

  // Commit notification
  output logic                                       commit_val,
  output pc_t                                        commit_pc,
  output logic [p_seq_num_bits-1:0]                  commit_seq_num,
  output reg_addr_t                                  commit_waddr,
  output word_t                                      commit_wdata,
  output logic                                       commit_wen
);

  // Completion pc stays internal, only the buffer needs it
  pc_t complete_pc;

  writeback_arbiter #(
    .p_num_pipes    (p_num_pipes),
    .p_seq_num_bits (p_seq_num_bits)
  ) arb0 (
    .clk              (clk),
    .rst_n            (rst_n),
    .ex_val           (ex_val),
    .ex_rdy           (ex_rdy),
    .ex_pc            (ex_pc),
    .ex_seq_num       (ex_seq_num),
    .ex_waddr         (ex_waddr),
    .ex_wdata         (ex_wdata),
    .ex_wen           (ex_wen),
    .complete_val     (complete_val),
    .complete_pc      (complete_pc),
    .complete_seq_num (complete_seq_num),
    .complete_waddr   (complete_waddr),
    .complete_wdata   (complete_wdata),
    .complete_wen     (complete_wen)
  );

  // Retires in program order
  reorder_buffer #(
    .p_seq_num_bits (p_seq_num_bits)
  ) rob0 (
    .clk              (clk),
    .rst_n            (rst_n),
    .complete_val     (complete_val),
    .complete_pc      (complete_pc),
    .complete_seq_num (complete_seq_num),
    .complete_waddr   (complete_waddr),
    .complete_wdata   (complete_wdata),
    .complete_wen     (complete_wen),
    .commit_val       (commit_val),
    .commit_pc        (commit_pc),
    .commit_seq_num   (commit_seq_num),
    .commit_waddr     (commit_waddr),
    .commit_wdata     (commit_wdata),
    .commit_wen       (commit_wen)
  );

endmodule

//--- tb/clock_gen.sv
// ----------------------------------------------------------------------
// Testbench clock and reset generator
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module clock_gen #(
  parameter int p_period_ns    = 4,
  parameter int p_reset_cycles = 5
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(p_period_ns / 2) clk = ~clk;
  end

  // Release on a falling edge, away from the flops' sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (p_reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

//--- tb/writeback_commit_unit_properties.sv
// ----------------------------------------------------------------------
// Writeback and commit unit properties
// Bound assertions on reset, arbitration, completion and in-order commit,
// backed by a shadow record of every accepted result
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module writeback_commit_unit_properties import wb_commit_pkg::*; #(
  parameter int p_num_pipes    = 2,
  parameter int p_seq_num_bits = 3
) (
  input logic                                       clk,
  input logic                                       rst_n,
  input logic [p_num_pipes-1:0]                     ex_val,
  input logic [p_num_pipes-1:0]                     ex_rdy,
  input pc_t  [p_num_pipes-1:0]                     ex_pc,
  input logic [p_num_pipes-1:0][p_seq_num_bits-1:0] ex_seq_num,
  input reg_addr_t [p_num_pipes-1:0]                ex_waddr,
  input word_t [p_num_pipes-1:0]                    ex_wdata,
  input logic [p_num_pipes-1:0]                     ex_wen,
  input logic                                       complete_val,
  input pc_t                                        complete_pc,
  input logic [p_seq_num_bits-1:0]                  complete_seq_num,
  input reg_addr_t                                  complete_waddr,
  input word_t                                      complete_wdata,
  input logic                                       complete_wen,
  input logic                                       commit_val,
  input pc_t                                        commit_pc,
  input logic [p_seq_num_bits-1:0]                  commit_seq_num,
  input reg_addr_t                                  commit_waddr,
  input word_t                                      commit_wdata,
  input logic                                       commit_wen
);

  localparam int p_depth = 2 ** p_seq_num_bits;

  // ----------------------------------------------------------------------
  // Shadow state
  // ----------------------------------------------------------------------

  // Low during reset and for one cycle after it
  logic                      rst_q;
  logic                      xfer_any;
  int                        xfer_idx;
  // Next sequence number expected on commit_val
  logic [p_seq_num_bits-1:0] exp_commit_seq;
  logic [p_seq_num_bits-1:0] rob_head;
  int                        wait_cnt [p_num_pipes];

  // Fields recorded at transfer, by sequence number and for the last one
  pc_t                       rec_pc    [p_depth];
  reg_addr_t                 rec_waddr [p_depth];
  word_t                     rec_wdata [p_depth];
  logic                      rec_wen   [p_depth];
  logic [p_seq_num_bits-1:0] last_seq;
  pc_t                       last_pc;
  reg_addr_t                 last_waddr;
  word_t                     last_wdata;
  logic                      last_wen;

  // Buffer head already moved past an entry whose commit_val is showing
  assign rob_head = exp_commit_seq + {{(p_seq_num_bits-1){1'b0}}, commit_val};

  always_comb begin
    xfer_any = 1'b0;
    xfer_idx = 0;
    for (int p = 0; p < p_num_pipes; p++) begin
      if (ex_val[p] && ex_rdy[p]) begin
        xfer_any = 1'b1;
        xfer_idx = p;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rst_q          <= 1'b0;
      exp_commit_seq <= '0;
      for (int p = 0; p < p_num_pipes; p++) wait_cnt[p] <= 0;
    end else begin
      rst_q <= 1'b1;
      if (commit_val) exp_commit_seq <= exp_commit_seq + p_seq_num_bits'(1);
      // Consecutive cycles of val without rdy
      for (int p = 0; p < p_num_pipes; p++) begin
        wait_cnt[p] <= (ex_val[p] && !ex_rdy[p]) ? wait_cnt[p] + 1 : 0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (xfer_any) begin
      rec_pc[ex_seq_num[xfer_idx]]    <= ex_pc[xfer_idx];
      rec_waddr[ex_seq_num[xfer_idx]] <= ex_waddr[xfer_idx];
      rec_wdata[ex_seq_num[xfer_idx]] <= ex_wdata[xfer_idx];
      rec_wen[ex_seq_num[xfer_idx]]   <= ex_wen[xfer_idx];
      last_seq   <= ex_seq_num[xfer_idx];
      last_pc    <= ex_pc[xfer_idx];
      last_waddr <= ex_waddr[xfer_idx];
      last_wdata <= ex_wdata[xfer_idx];
      last_wen   <= ex_wen[xfer_idx];
    end
  end

  // ----------------------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------------------

  a_reset: assert property (@(posedge clk)
    !rst_q |-> (!complete_val && !commit_val && ex_rdy == '0))
    else $error("** Error reset: expected 0 actual complete_val=%b commit_val=%b ex_rdy=%b",
                complete_val, commit_val, ex_rdy);

  a_one_rdy: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(ex_rdy))
    else $error("More than one pipe saw rdy in the same cycle, ex_rdy=%b", ex_rdy);

  for (genvar p = 0; p < p_num_pipes; p++) begin : g_fair
    a_fair: assert property (@(posedge clk) disable iff (!rst_n) wait_cnt[p] < p_num_pipes)
      else $error("Pipe %0d held val for %0d cycles without rdy", p, wait_cnt[p]);
  end

  a_complete: assert property (@(posedge clk) disable iff (!rst_n)
    xfer_any |=> (complete_val && complete_seq_num == last_seq && complete_pc == last_pc &&
                  complete_waddr == last_waddr && complete_wdata == last_wdata &&
                  complete_wen == last_wen))
    else $error("** Error completion: expected seq %0d wdata %h actual val %b seq %0d wdata %h",
                last_seq, last_wdata, complete_val, complete_seq_num, complete_wdata);

  a_commit_order: assert property (@(posedge clk) disable iff (!rst_n)
    commit_val |-> commit_seq_num == exp_commit_seq)
    else $error("** Error commit_order: expected %0d actual %0d", exp_commit_seq, commit_seq_num);

  a_commit_data: assert property (@(posedge clk) disable iff (!rst_n)
    commit_val |-> (commit_pc == rec_pc[commit_seq_num] &&
                    commit_waddr == rec_waddr[commit_seq_num] &&
                    commit_wdata == rec_wdata[commit_seq_num] &&
                    commit_wen == rec_wen[commit_seq_num]))
    else $error("** Error commit_data: expected pc %h wdata %h actual pc %h wdata %h",
                rec_pc[commit_seq_num], rec_wdata[commit_seq_num], commit_pc, commit_wdata);

  // Head completion retires at the very next edge
  a_head_latency: assert property (@(posedge clk) disable iff (!rst_n)
    (complete_val && complete_seq_num == rob_head) |=>
      (commit_val && commit_seq_num == $past(complete_seq_num)))
    else $error("** Error head_latency: expected commit of %0d actual val %b seq %0d",
                $past(complete_seq_num), commit_val, commit_seq_num);

endmodule

bind writeback_commit_unit writeback_commit_unit_properties #(
  .p_num_pipes    (p_num_pipes),
  .p_seq_num_bits (p_seq_num_bits)
) props0 (.*);

//--- tb/writeback_commit_unit_tb.sv
// ----------------------------------------------------------------------
// Writeback and commit unit testbench
// Sends shuffled batches of results over two pipes and counts commits
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module writeback_commit_unit_tb import wb_commit_pkg::*; ();

  localparam int num_pipes      = 2;
  localparam int seq_bits       = 3;
  localparam int num_instr      = 40;
  localparam int batch_size     = 8;
  localparam int timeout_cycles = 64;

  logic                               clk;
  logic                               rst_n;
  logic [num_pipes-1:0]               ex_val;
  logic [num_pipes-1:0]               ex_rdy;
  pc_t  [num_pipes-1:0]               ex_pc;
  logic [num_pipes-1:0][seq_bits-1:0] ex_seq_num;
  reg_addr_t [num_pipes-1:0]          ex_waddr;
  word_t [num_pipes-1:0]              ex_wdata;
  logic [num_pipes-1:0]               ex_wen;
  logic                               complete_val;
  logic [seq_bits-1:0]                complete_seq_num;
  reg_addr_t                          complete_waddr;
  word_t                              complete_wdata;
  logic                               complete_wen;
  logic                               commit_val;
  pc_t                                commit_pc;
  logic [seq_bits-1:0]                commit_seq_num;
  reg_addr_t                          commit_waddr;
  word_t                              commit_wdata;
  logic                               commit_wen;

  // Instruction table in program order
  pc_t       instr_pc    [num_instr];
  reg_addr_t instr_waddr [num_instr];
  word_t     instr_wdata [num_instr];
  logic      instr_wen   [num_instr];
  // Offer order inside a batch, and the pipe for each position
  int        order       [batch_size];
  int        pipe_of     [batch_size];

  integer seed;
  int     commit_count;
  logic   pass_flag;
  logic   fail_reported;

  clock_gen #(.p_period_ns(4), .p_reset_cycles(5)) clk0 (.clk(clk), .rst_n(rst_n));

  writeback_commit_unit #(
    .p_num_pipes    (num_pipes),
    .p_seq_num_bits (seq_bits)
  ) dut0 (
    .clk (clk), .rst_n (rst_n),
    .ex_val (ex_val), .ex_rdy (ex_rdy), .ex_pc (ex_pc), .ex_seq_num (ex_seq_num),
    .ex_waddr (ex_waddr), .ex_wdata (ex_wdata), .ex_wen (ex_wen),
    .complete_val (complete_val), .complete_seq_num (complete_seq_num),
    .complete_waddr (complete_waddr), .complete_wdata (complete_wdata),
    .complete_wen (complete_wen),
    .commit_val (commit_val), .commit_pc (commit_pc), .commit_seq_num (commit_seq_num),
    .commit_waddr (commit_waddr), .commit_wdata (commit_wdata), .commit_wen (commit_wen)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) commit_count <= 0;
    else if (commit_val) commit_count <= commit_count + 1;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  task automatic report_timeout(input string what);
    fail_reported = 1'b1;
    $display("TEST RESULT: FAIL");
    $display("Timed out waiting for %s", what);
    $fatal(1, "Run stopped after a timeout");
  endtask

  // Unknown counts as still in reset
  task automatic wait_reset_release();
    int waited;
    waited = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited > timeout_cycles) report_timeout("reset release");
    end
  endtask

  task automatic wait_commits(input int target);
    int waited;
    waited = 0;
    while (commit_count < target) begin
      @(negedge clk);
      waited++;
      if (waited > timeout_cycles) report_timeout("commit_val pulses");
    end
  endtask

  task automatic make_table();
    for (int i = 0; i < num_instr; i++) begin
      instr_pc[i]    = pc_t'(32'h0000_1000 + 4 * i);
      instr_waddr[i] = reg_addr_t'($random(seed));
      instr_wdata[i] = word_t'($random(seed));
      instr_wen[i]   = 1'($random(seed));
    end
  endtask

  // Fisher-Yates over the batch positions, random pipe per position
  task automatic shuffle_batch();
    int j;
    int tmp;
    for (int k = 0; k < batch_size; k++) begin
      order[k]   = k;
      pipe_of[k] = int'($unsigned($random(seed)) % num_pipes);
    end
    for (int k = batch_size - 1; k > 0; k--) begin
      j        = int'($unsigned($random(seed)) % (k + 1));
      tmp      = order[k];
      order[k] = order[j];
      order[j] = tmp;
    end
  endtask

  // First position at or after from that belongs to pipe p
  function automatic int next_pos(input int p, input int from);
    int pos;
    pos = from;
    while (pos < batch_size && pipe_of[pos] != p) pos++;
    return pos;
  endfunction

  // Both pipes offer in parallel, each holds val and data until rdy
  task automatic send_batch(input int base);
    int                   cur    [num_pipes];
    int                   waited [num_pipes];
    int                   remaining;
    int                   idx;
    logic [num_pipes-1:0] granted;
    remaining = batch_size;
    for (int p = 0; p < num_pipes; p++) begin
      cur[p]    = next_pos(p, 0);
      waited[p] = 0;
    end
    while (remaining > 0) begin
      @(negedge clk);
      for (int p = 0; p < num_pipes; p++) begin
        if (cur[p] < batch_size) begin
          idx           = base + order[cur[p]];
          ex_val[p]     = 1'b1;
          ex_pc[p]      = instr_pc[idx];
          ex_seq_num[p] = seq_bits'(idx);
          ex_waddr[p]   = instr_waddr[idx];
          ex_wdata[p]   = instr_wdata[idx];
          ex_wen[p]     = instr_wen[idx];
        end else begin
          ex_val[p] = 1'b0;
        end
      end
      // Mid low phase, rdy has settled
      #1;
      granted = ex_val & ex_rdy;
      @(posedge clk);
      for (int p = 0; p < num_pipes; p++) begin
        if (granted[p]) begin
          remaining--;
          cur[p]    = next_pos(p, cur[p] + 1);
          waited[p] = 0;
        end else if (cur[p] < batch_size) begin
          waited[p]++;
          if (waited[p] > timeout_cycles) report_timeout("ex_rdy on a waiting pipe");
        end
      end
    end
    @(negedge clk);
    ex_val = '0;
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    seed          = 1910;
    pass_flag     = 1'b0;
    fail_reported = 1'b0;
    ex_val        = '0;
    ex_pc         = '0;
    ex_seq_num    = '0;
    ex_waddr      = '0;
    ex_wdata      = '0;
    ex_wen        = '0;
    make_table();
    wait_reset_release();
    repeat (2) @(negedge clk);
    // At most one batch in flight
    for (int b = 0; b < num_instr / batch_size; b++) begin
      shuffle_batch();
      send_batch(b * batch_size);
      wait_commits((b + 1) * batch_size);
    end
    // Quiet period, catches a stray extra commit
    repeat (10) @(negedge clk);
    if (commit_count != num_instr) begin
      fail_reported = 1'b1;
      $display("** Error commit_count: expected %0d actual %0d", num_instr, commit_count);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Wrong number of commits");
    end else begin
      pass_flag = 1'b1;
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

  // Run ended by an assertion
  final begin
    if (!pass_flag && !fail_reported) $display("TEST RESULT: FAIL");
  end

endmodule

//--- writeback_commit_unit.f
design/wb_commit_pkg.sv
design/writeback_arbiter.sv
design/reorder_buffer.sv
design/writeback_commit_unit.sv
tb/clock_gen.sv
tb/writeback_commit_unit_properties.sv
tb/writeback_commit_unit_tb.sv

//--- Makefile
# Verilator build for the writeback and commit unit testbench

VERILATOR ?= verilator
TOP       := writeback_commit_unit_tb
FILELIST  := writeback_commit_unit.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Exit status of the model is the test result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
